// File: fetch_fifo.sv
`timescale 1ns/1ps

module fetch_fifo
  import rvc_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        flush,
  input  fetch_word_t in_word,
  input  logic        in_valid,
  output logic        in_ready,
  output fetch_word_t head,
  output logic        head_valid,
  input  logic        pop
);

  fetch_word_t           mem [fifo_depth];
  logic [fifo_ptr_w-1:0] rd_ptr;
  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_ptr_w:0]   count;
  logic                  push;
  logic                  pop_fire;

  // No new words while a redirect is flushing the queue.
  assign in_ready   = (count < fifo_depth) && !flush;
  assign push       = in_valid && in_ready;
  assign pop_fire   = pop && head_valid;
  assign head       = mem[rd_ptr];
  assign head_valid = (count != '0);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_word;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == fifo_ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr <= (rd_ptr == fifo_ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Push and pop together keep the level.
      endcase
    end
  end

endmodule

// File: inst_aligner.sv
`timescale 1ns/1ps

module inst_aligner
  import rvc_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            redirect,
  input  logic [xlen-1:0] redirect_pc,
  input  fetch_word_t     head,
  input  logic            head_valid,
  output logic            pop,
  output parcel_t         parcel,
  output logic            parcel_valid,
  input  logic            parcel_ready
);

  align_state_e      state;
  logic [half_w-1:0] held_half;
  logic [xlen-1:0]   held_pc;
  logic [half_w-1:0] low_half;
  logic [half_w-1:0] high_half;
  logic              low_is_c;
  logic              high_is_c;
  logic [xlen-1:0]   high_pc;
  logic              split_start;
  logic              fire;

  assign low_half  = head.data[half_w-1:0];
  assign high_half = head.data[xlen-1:half_w];
  assign low_is_c  = (low_half[1:0] != 2'b11);
  assign high_is_c = (high_half[1:0] != 2'b11);
  assign high_pc   = head.pc + xlen'(2);
  assign fire      = parcel_valid && parcel_ready;

  // A 32-bit instruction begins in the upper half and needs the next word.
  assign split_start = (state == AL_HIGH) && head_valid && !high_is_c;

  always_comb begin
    parcel_valid      = 1'b0;
    pop               = 1'b0;
    parcel.pc         = head.pc;
    parcel.bits       = head.data;
    parcel.compressed = 1'b0;
    case (state)
      AL_LOW: begin
        parcel_valid = head_valid;
        if (low_is_c) begin
          parcel.bits       = {{half_w{1'b0}}, low_half};
          parcel.compressed = 1'b1;
        end else begin
          pop = head_valid && parcel_ready;  // Whole word is one instruction.
        end
      end
      AL_HIGH: begin
        parcel.pc         = high_pc;
        parcel.bits       = {{half_w{1'b0}}, high_half};
        parcel.compressed = 1'b1;
        if (high_is_c) begin
          parcel_valid = head_valid;
          pop          = head_valid && parcel_ready;
        end else begin
          pop = head_valid;  // Upper half moves into the holding register.
        end
      end
      AL_SPLIT: begin
        parcel_valid = head_valid;
        parcel.pc    = held_pc;
        parcel.bits  = {low_half, held_half};
      end
      default: begin
        parcel_valid = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= AL_LOW;
      held_half <= '0;
    end else if (redirect) begin
      state     <= redirect_pc[1] ? AL_HIGH : AL_LOW;  // Skip the low half on odd starts.
      held_half <= '0;
    end else begin
      case (state)
        AL_LOW: begin
          if (fire && low_is_c) state <= AL_HIGH;
        end
        AL_HIGH: begin
          if (split_start) begin
            state     <= AL_SPLIT;
            held_half <= high_half;
          end else if (fire) begin
            state <= AL_LOW;
          end
        end
        AL_SPLIT: begin
          if (fire) state <= AL_HIGH;  // The next word's upper half is still unread.
        end
        default: state <= AL_LOW;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (split_start) begin
      held_pc <= high_pc;
    end
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f rvc_frontend.f --top-module rvc_frontend_tb -o rvc_frontend_sim
out=$(./obj_dir/rvc_frontend_sim)
echo "$out"
grep -qx "=== PASS ===" <<< "$out"

// File: rvc_expander.sv
`timescale 1ns/1ps

module rvc_expander
  import rvc_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    flush,
  input  parcel_t parcel,
  input  logic    parcel_valid,
  output logic    parcel_ready,
  output inst_t   inst_out,
  output logic    inst_valid,
  input  logic    inst_ready
);

  logic [half_w-1:0] c;
  rvc_op_e           op;
  logic [4:0]        rd;
  logic [4:0]        rs2;
  logic [4:0]        rs1_p;
  logic [4:0]        rs2_p;
  logic [4:0]        shamt;
  logic [11:0]       imm6;
  logic [11:0]       sp_off;
  logic [11:0]       lw_off;
  logic [19:0]       lui_imm;
  logic [20:0]       j_off;
  logic [12:0]       b_off;
  logic [xlen-1:0]   expanded;
  inst_t             next_inst;

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd_f,
                                        input rv_opcode_e opc);
    return {imm, rs1, f3, rd_f, opc};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2_f,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd_f);
    return {f7, rs2_f, rs1, f3, rd_f, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2_f,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2_f, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2_f,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2_f, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd_f);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd_f, OPC_JAL};
  endfunction

  assign c     = parcel.bits[half_w-1:0];
  assign op    = rvc_classify(c);
  assign rd    = c[11:7];
  assign rs2   = c[6:2];
  assign rs1_p = {2'b01, c[9:7]};  // Three-bit fields address x8 to x15.
  assign rs2_p = {2'b01, c[4:2]};
  assign shamt = c[6:2];

  // Immediates, scrambled in the compressed format, put back in bit order.
  assign imm6    = {{6{c[12]}}, c[12], c[6:2]};
  assign sp_off  = {{2{c[12]}}, c[12], c[4:3], c[5], c[2], c[6], 4'b0000};
  assign lw_off  = {5'b00000, c[5], c[12:10], c[6], 2'b00};
  assign lui_imm = {{14{c[12]}}, c[12], c[6:2]};
  assign j_off   = {{9{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
  assign b_off   = {{4{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};

  always_comb begin
    case (op)
      RVC_ADDI:     expanded = enc_i(imm6, rd, 3'b000, rd, OPC_OP_IMM);
      RVC_NOP:      expanded = enc_i(12'd0, 5'd0, 3'b000, 5'd0, OPC_OP_IMM);
      RVC_LI:       expanded = enc_i(imm6, 5'd0, 3'b000, rd, OPC_OP_IMM);
      RVC_LUI:      expanded = {lui_imm, rd, OPC_LUI};
      RVC_ADDI16SP: expanded = enc_i(sp_off, 5'd2, 3'b000, 5'd2, OPC_OP_IMM);
      RVC_LW:       expanded = enc_i(lw_off, rs1_p, 3'b010, rs2_p, OPC_LOAD);
      RVC_SW:       expanded = enc_s(lw_off, rs2_p, rs1_p, 3'b010);
      RVC_J:        expanded = enc_j(j_off, 5'd0);
      RVC_JAL:      expanded = enc_j(j_off, 5'd1);  // Links through ra.
      RVC_BEQZ:     expanded = enc_b(b_off, 5'd0, rs1_p, 3'b000);
      RVC_BNEZ:     expanded = enc_b(b_off, 5'd0, rs1_p, 3'b001);
      RVC_MV:       expanded = enc_r(7'b0000000, rs2, 5'd0, 3'b000, rd);
      RVC_ADD:      expanded = enc_r(7'b0000000, rs2, rd, 3'b000, rd);
      RVC_JR:       expanded = enc_i(12'd0, rd, 3'b000, 5'd0, OPC_JALR);
      RVC_JALR:     expanded = enc_i(12'd0, rd, 3'b000, 5'd1, OPC_JALR);
      RVC_SLLI:     expanded = enc_i({7'b0000000, shamt}, rd, 3'b001, rd, OPC_OP_IMM);
      RVC_SRLI:     expanded = enc_i({7'b0000000, shamt}, rs1_p, 3'b101, rs1_p, OPC_OP_IMM);
      RVC_SRAI:     expanded = enc_i({7'b0100000, shamt}, rs1_p, 3'b101, rs1_p, OPC_OP_IMM);
      RVC_ANDI:     expanded = enc_i(imm6, rs1_p, 3'b111, rs1_p, OPC_OP_IMM);
      RVC_SUB:      expanded = enc_r(7'b0100000, rs2_p, rs1_p, 3'b000, rs1_p);
      RVC_XOR:      expanded = enc_r(7'b0000000, rs2_p, rs1_p, 3'b100, rs1_p);
      RVC_OR:       expanded = enc_r(7'b0000000, rs2_p, rs1_p, 3'b110, rs1_p);
      RVC_AND:      expanded = enc_r(7'b0000000, rs2_p, rs1_p, 3'b111, rs1_p);
      default:      expanded = {{half_w{1'b0}}, c};  // Raw half-word goes on for the trap.
    endcase
  end

  always_comb begin
    next_inst.pc         = parcel.pc;
    next_inst.compressed = parcel.compressed;
    if (parcel.compressed) begin
      next_inst.inst    = expanded;
      next_inst.illegal = (op == RVC_ILLEGAL);
    end else begin
      next_inst.inst    = parcel.bits;
      next_inst.illegal = 1'b0;
    end
  end

  assign parcel_ready = !inst_valid || inst_ready;

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      inst_valid <= 1'b0;
    end else if (parcel_valid && parcel_ready) begin
      inst_valid <= 1'b1;
    end else if (inst_ready) begin
      inst_valid <= 1'b0;
    end
  end

  // Loads only on a transfer, so a stalled output stays put.
  always_ff @(posedge clk) begin
    if (parcel_valid && parcel_ready) begin
      inst_out <= next_inst;
    end
  end

endmodule

// File: rvc_frontend.f
+incdir+.
rvc_pkg.sv
fetch_fifo.sv
inst_aligner.sv
rvc_expander.sv
rvc_frontend.sv
rvc_frontend_tb.sv

// File: rvc_frontend.sv
`timescale 1ns/1ps

module rvc_frontend
  import rvc_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  fetch_word_t     fetch_in,
  input  logic            fetch_valid,
  output logic            fetch_ready,
  input  logic            redirect,
  input  logic [xlen-1:0] redirect_pc,
  output inst_t           inst_out,
  output logic            inst_valid,
  input  logic            inst_ready
);

  fetch_word_t head;
  logic        head_valid;
  logic        pop;
  parcel_t     parcel;
  logic        parcel_valid;
  logic        parcel_ready;

  // Two words of slack let the aligner use one word while fetch delivers the next.
  fetch_fifo i_fetch_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (redirect),
    .in_word    (fetch_in),
    .in_valid   (fetch_valid),
    .in_ready   (fetch_ready),
    .head       (head),
    .head_valid (head_valid),
    .pop        (pop)
  );

  inst_aligner i_inst_aligner (
    .clk          (clk),
    .rst_n        (rst_n),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .head         (head),
    .head_valid   (head_valid),
    .pop          (pop),
    .parcel       (parcel),
    .parcel_valid (parcel_valid),
    .parcel_ready (parcel_ready)
  );

  rvc_expander i_rvc_expander (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush        (redirect),  // Drops an instruction from the old path.
    .parcel       (parcel),
    .parcel_valid (parcel_valid),
    .parcel_ready (parcel_ready),
    .inst_out     (inst_out),
    .inst_valid   (inst_valid),
    .inst_ready   (inst_ready)
  );

endmodule

// File: rvc_frontend_tb_table.svh
// Steps: redirect flag, redirect PC, fetch word PC, fetch word data.
// Expects: step, PC, expanded instruction, compressed, illegal.
localparam int n_steps = 14;
localparam int n_expects = 22;

string step_name [n_steps] = '{
  "rv32_addi", "rv32_lw", "c_addi_li", "c_lw_sw", "c_beqz_j", "c_mv_add", "c_sub_srli",
  "straddle_start", "straddle_end", "c_reserved", "c_lui_held", "redirect_odd",
  "c_jr_andi", "rv32_add"
};

step_t steps [n_steps] = '{
  {1'b0, 32'h0000_0000, 32'h0000_0100, 32'h0050_0093},
  {1'b0, 32'h0000_0000, 32'h0000_0104, 32'h0081_2283},
  {1'b0, 32'h0000_0000, 32'h0000_0108, 32'h459d_1575},
  {1'b0, 32'h0000_0000, 32'h0000_010c, 32'hc488_4044},
  {1'b0, 32'h0000_0000, 32'h0000_0110, 32'hbff5_c401},
  {1'b0, 32'h0000_0000, 32'h0000_0114, 32'h963a_8636},
  {1'b0, 32'h0000_0000, 32'h0000_0118, 32'h810d_8c05},
  {1'b0, 32'h0000_0000, 32'h0000_011c, 32'h52b7_0001},  // C.NOP, then lui starts.
  {1'b0, 32'h0000_0000, 32'h0000_0120, 32'h0292_1234},
  {1'b0, 32'h0000_0000, 32'h0000_0124, 32'h6101_0000},
  {1'b0, 32'h0000_0000, 32'h0000_0128, 32'h0513_6785},  // Upper half is left held.
  {1'b1, 32'h0000_0202, 32'h0000_0200, 32'h2801_4505},
  {1'b0, 32'h0000_0000, 32'h0000_0204, 32'h98fd_8082},
  {1'b0, 32'h0000_0000, 32'h0000_0208, 32'h0020_81b3}
};

expect_t expects [n_expects] = '{
  {32'd0, 32'h0000_0100, 32'h0050_0093, 1'b0, 1'b0},
  {32'd1, 32'h0000_0104, 32'h0081_2283, 1'b0, 1'b0},
  {32'd2, 32'h0000_0108, 32'hffd5_0513, 1'b1, 1'b0},
  {32'd2, 32'h0000_010a, 32'h0070_0593, 1'b1, 1'b0},
  {32'd3, 32'h0000_010c, 32'h0044_2483, 1'b1, 1'b0},
  {32'd3, 32'h0000_010e, 32'h00a4_a423, 1'b1, 1'b0},
  {32'd4, 32'h0000_0110, 32'h0004_0463, 1'b1, 1'b0},
  {32'd4, 32'h0000_0112, 32'hffdf_f06f, 1'b1, 1'b0},
  {32'd5, 32'h0000_0114, 32'h00d0_0633, 1'b1, 1'b0},
  {32'd5, 32'h0000_0116, 32'h00e6_0633, 1'b1, 1'b0},
  {32'd6, 32'h0000_0118, 32'h4094_0433, 1'b1, 1'b0},
  {32'd6, 32'h0000_011a, 32'h0035_5513, 1'b1, 1'b0},
  {32'd7, 32'h0000_011c, 32'h0000_0013, 1'b1, 1'b0},
  {32'd8, 32'h0000_011e, 32'h1234_52b7, 1'b0, 1'b0},
  {32'd8, 32'h0000_0122, 32'h0042_9293, 1'b1, 1'b0},
  {32'd9, 32'h0000_0124, 32'h0000_0000, 1'b1, 1'b1},
  {32'd9, 32'h0000_0126, 32'h0000_6101, 1'b1, 1'b1},
  {32'd10, 32'h0000_0128, 32'h0000_17b7, 1'b1, 1'b0},
  {32'd11, 32'h0000_0202, 32'h0100_00ef, 1'b1, 1'b0},
  {32'd12, 32'h0000_0204, 32'h0000_8067, 1'b1, 1'b0},
  {32'd12, 32'h0000_0206, 32'hfff4_f493, 1'b1, 1'b0},
  {32'd13, 32'h0000_0208, 32'h0020_81b3, 1'b0, 1'b0}
};

// File: rvc_frontend_tb.sv
`timescale 1ns/1ps

module rvc_frontend_tb
  import rvc_pkg::*;
();

  localparam int half_period = 4;

  typedef struct packed {
    logic            redir;
    logic [xlen-1:0] redir_pc;
    fetch_word_t     word;
  } step_t;

  typedef struct packed {
    int    step;  // Row of the table whose word completes this instruction.
    inst_t inst;
  } expect_t;

  logic            clk;
  logic            rst_n;
  fetch_word_t     fetch_in;
  logic            fetch_valid;
  logic            fetch_ready;
  logic            redirect;
  logic [xlen-1:0] redirect_pc;
  inst_t           inst_out;
  logic            inst_valid;
  logic            inst_ready;

  expect_t exp_q [$];
  int      value_errors = 0;
  int      protocol_errors = 0;
  int      cycles = 0;
  logic    stalled = 1'b0;
  inst_t   stalled_out;

  `include "rvc_frontend_tb_table.svh"

  localparam int cycle_limit = 20 * n_steps + 100;

  rvc_frontend i_rvc_frontend (.*);

  always #half_period clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // Outputs and inst_ready are stable here until the next rising edge.
  always @(negedge clk) begin
    expect_t e;
    if (stalled) begin
      assert (inst_valid && inst_out == stalled_out) else begin
        $display("inst_out changed or lost valid while inst_ready was low.");
        protocol_errors++;
      end
    end
    inst_ready  = (($urandom % 100) >= 40);
    stalled     = inst_valid && !inst_ready;
    stalled_out = inst_out;
    if (inst_valid && inst_ready) begin
      assert (exp_q.size() != 0) else begin
        $display("An instruction at pc %h came out when none was expected.", inst_out.pc);
        protocol_errors++;
      end
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        assert (inst_out == e.inst) else begin
          $display("ERROR %s: expected pc %h inst %h c %b ill %b, actual pc %h inst %h c %b ill %b",
                   step_name[e.step], e.inst.pc, e.inst.inst, e.inst.compressed,
                   e.inst.illegal, inst_out.pc, inst_out.inst, inst_out.compressed,
                   inst_out.illegal);
          value_errors++;
        end
      end
    end
  end

  // Called on a falling edge and returns on the falling edge after the transfer.
  task automatic offer_word(input fetch_word_t w);
    logic taken;
    taken       = 1'b0;
    fetch_in    = w;
    fetch_valid = 1'b1;
    while (!taken) begin
      #(half_period / 2);
      taken = fetch_ready;
      @(negedge clk);
    end
    fetch_valid = 1'b0;
  endtask

  task automatic send_redirect(input logic [xlen-1:0] pc);
    while (exp_q.size() != 0) @(negedge clk);
    redirect    = 1'b1;
    redirect_pc = pc;
    @(negedge clk);
    redirect = 1'b0;
  endtask

  initial begin
    int e_idx;
    e_idx       = 0;
    clk         = 1'b0;
    rst_n       = 1'b0;
    fetch_in    = '0;
    fetch_valid = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    inst_ready  = 1'b0;
    void'($urandom(32'hf3ac_e809));
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    assert (!inst_valid && fetch_ready) else begin
      $display("The DUT is not idle after reset.");
      protocol_errors++;
    end
    for (int i = 0; i < n_steps; i++) begin
      if (steps[i].redir) send_redirect(steps[i].redir_pc);
      while (e_idx < n_expects && expects[e_idx].step == i) begin
        exp_q.push_back(expects[e_idx]);
        e_idx++;
      end
      offer_word(steps[i].word);
    end
    repeat (100) begin
      if (exp_q.size() == 0) break;
      @(negedge clk);
    end
    repeat (10) @(negedge clk);  // Room for any extra instruction to show up.
    assert (exp_q.size() == 0) else begin
      $display("%0d expected instructions never came out.", exp_q.size());
      protocol_errors++;
    end
    $display("Done: %0d value errors, %0d protocol errors.", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: rvc_pkg.sv
package rvc_pkg;

  localparam int xlen = 32;
  localparam int half_w = 16;
  localparam int fifo_depth = 2;
  localparam int fifo_ptr_w = $clog2(fifo_depth);

  typedef struct packed {
    logic [xlen-1:0] pc;    // Word-aligned fetch address.
    logic [xlen-1:0] data;
  } fetch_word_t;

  // Upper half of bits is zero when the parcel is compressed.
  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] bits;
    logic            compressed;
  } parcel_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
    logic            compressed;
    logic            illegal;
  } inst_t;

  typedef enum logic [4:0] {
    RVC_ADDI, RVC_NOP, RVC_LI, RVC_LUI, RVC_ADDI16SP,
    RVC_LW, RVC_SW,
    RVC_J, RVC_JAL, RVC_BEQZ, RVC_BNEZ,
    RVC_MV, RVC_ADD, RVC_JR, RVC_JALR,
    RVC_SLLI, RVC_SRLI, RVC_SRAI, RVC_ANDI,
    RVC_SUB, RVC_XOR, RVC_OR, RVC_AND,
    RVC_ILLEGAL
  } rvc_op_e;

  typedef enum logic [1:0] {
    AL_LOW,
    AL_HIGH,
    AL_SPLIT
  } align_state_e;

  // Major opcodes of the RV32I forms the expander produces.
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111
  } rv_opcode_e;

  // Quadrant and funct3 select the group; the rest only separates reserved forms.
  function automatic rvc_op_e rvc_classify(input logic [half_w-1:0] c);
    rvc_op_e op;
    op = RVC_ILLEGAL;
    case ({c[1:0], c[15:13]})
      5'b00_010: op = RVC_LW;
      5'b00_110: op = RVC_SW;
      5'b01_000: op = (c[11:7] == 5'd0) ? RVC_NOP : RVC_ADDI;
      5'b01_001: op = RVC_JAL;
      5'b01_010: op = RVC_LI;
      5'b01_011: begin
        if ({c[12], c[6:2]} != 6'd0) begin
          op = (c[11:7] == 5'd2) ? RVC_ADDI16SP : RVC_LUI;
        end
      end
      5'b01_100: begin
        case (c[11:10])
          2'b00: if (!c[12]) op = RVC_SRLI;  // Shamt bit 5 is reserved on RV32.
          2'b01: if (!c[12]) op = RVC_SRAI;
          2'b10: op = RVC_ANDI;
          default: begin
            if (!c[12]) begin
              case (c[6:5])
                2'b00:   op = RVC_SUB;
                2'b01:   op = RVC_XOR;
                2'b10:   op = RVC_OR;
                default: op = RVC_AND;
              endcase
            end
          end
        endcase
      end
      5'b01_101: op = RVC_J;
      5'b01_110: op = RVC_BEQZ;
      5'b01_111: op = RVC_BNEZ;
      5'b10_000: if (!c[12]) op = RVC_SLLI;
      5'b10_100: begin
        if (!c[12]) begin
          if (c[6:2] != 5'd0) op = RVC_MV;
          else if (c[11:7] != 5'd0) op = RVC_JR;
        end else begin
          if (c[6:2] != 5'd0) op = RVC_ADD;
          else if (c[11:7] != 5'd0) op = RVC_JALR;  // rs1 of zero is EBREAK.
        end
      end
      default: op = RVC_ILLEGAL;
    endcase
    return op;
  endfunction

endpackage
